//--- common/bg_consts.svh
`ifndef BG_CONSTS_SVH
`define BG_CONSTS_SVH

// visible area
`define H_PIXELS        1024
`define V_PIXELS        768
`define COUNT_W         11

`define NUM_PLATFORMS   4
`define HORIZON_ROW     550
`define BEVEL_ROWS      3

// 12-bit colours, one nibble per channel
`define COL_BLACK       12'h0_0_0
`define COL_TOP         12'hf_f_0   // yellow
`define COL_BOTTOM      12'hf_0_0   // red
`define COL_LEFT        12'h0_f_0   // green
`define COL_RIGHT       12'h0_0_f   // blue
`define COL_PLATFORM    12'h1_1_1   // dark grey fill
`define COL_GRASS       12'h0_b_0
`define COL_SKY         12'h0_a_f

// apb register map
`define APB_ADDR_W      8
`define APB_DATA_W      32
`define REG_STRIDE      8           // bytes per platform
`define REG_X_OFFSET    0
`define REG_Y_OFFSET    4

// field positions, same for x and y words
`define REG_START_LSB   0
`define REG_END_LSB     16
`define REG_EN_BIT      31          // x word only

`endif

//--- common/bg_pkg.sv
package bg_pkg;

`include "bg_consts.svh"

    // pixel coordinate
    typedef logic [`COUNT_W-1:0] count_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one platform as loaded over apb
    typedef struct packed {
        logic   enable;
        count_t x_start;
        count_t x_end;
        count_t y_start;
        count_t y_end;
    } platform_t;

    typedef struct packed {
        logic fill;
        logic bevel;
    } hit_t;

endpackage

//--- common/vga_bus.sv
`timescale 1ns/1ps

interface vga_bus;

    bg_pkg::count_t hcount;
    bg_pkg::count_t vcount;
    logic           hsync;
    logic           vsync;
    logic           hblnk;
    logic           vblnk;

    modport source (
        output hcount, vcount,
        output hsync, vsync,
        output hblnk, vblnk
    );

    modport sink (
        input hcount, vcount,
        input hsync, vsync,
        input hblnk, vblnk
    );

endinterface

//--- platforms/platform_regs.sv
`timescale 1ns/1ps

`include "bg_consts.svh"

module platform_regs (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [`APB_ADDR_W-1:0]        paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`APB_DATA_W-1:0]        pwdata,
    output logic [`APB_DATA_W-1:0]        prdata,
    output logic                          pready,
    output logic                          pslverr,

    output bg_pkg::platform_t [`NUM_PLATFORMS-1:0] platforms
);

    localparam int IDX_W = $clog2(`NUM_PLATFORMS);

    logic                   access;
    logic                   addr_ok;
    logic                   sel_y;
    logic [`APB_ADDR_W-1:0] word_idx;
    logic [`APB_ADDR_W-1:0] word_off;
    logic [IDX_W-1:0]       idx;
    logic [`APB_DATA_W-1:0] rd_word;

    assign access   = psel && penable;
    assign word_idx = paddr / `APB_ADDR_W'(`REG_STRIDE);
    assign word_off = paddr % `APB_ADDR_W'(`REG_STRIDE);
    assign idx      = word_idx[IDX_W-1:0];
    assign sel_y    = (word_off == `APB_ADDR_W'(`REG_Y_OFFSET));

    assign addr_ok = (word_idx < `APB_ADDR_W'(`NUM_PLATFORMS)) &&
                     ((word_off == `APB_ADDR_W'(`REG_X_OFFSET)) || sel_y);

    // zero wait states
    assign pready  = access;
    assign pslverr = access && !addr_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            platforms <= '0;    // all disabled
        end else if (access && pwrite && addr_ok) begin
            if (sel_y) begin
                platforms[idx].y_start <= pwdata[`REG_START_LSB +: `COUNT_W];
                platforms[idx].y_end   <= pwdata[`REG_END_LSB +: `COUNT_W];
            end else begin
                platforms[idx].x_start <= pwdata[`REG_START_LSB +: `COUNT_W];
                platforms[idx].x_end   <= pwdata[`REG_END_LSB +: `COUNT_W];
                platforms[idx].enable  <= pwdata[`REG_EN_BIT];
            end
        end
    end

    // read-back word, unused bits read zero
    always_comb begin
        rd_word = '0;
        if (sel_y) begin
            rd_word[`REG_START_LSB +: `COUNT_W] = platforms[idx].y_start;
            rd_word[`REG_END_LSB +: `COUNT_W]   = platforms[idx].y_end;
        end else begin
            rd_word[`REG_START_LSB +: `COUNT_W] = platforms[idx].x_start;
            rd_word[`REG_END_LSB +: `COUNT_W]   = platforms[idx].x_end;
            rd_word[`REG_EN_BIT]                = platforms[idx].enable;
        end
    end

    assign prdata = (access && addr_ok) ? rd_word : '0;

endmodule

//--- platforms/platform_hit.sv
`timescale 1ns/1ps

`include "bg_consts.svh"

module platform_hit (
    input  logic              clk,
    input  logic              rst,

    vga_bus.sink              pos,
    input  bg_pkg::platform_t platform,
    output bg_pkg::hit_t      hit
);

    // one extra bit so x_end + 3 cannot wrap
    localparam int SUM_W = `COUNT_W + 1;

    logic [SUM_W-1:0] h_w;
    logic [SUM_W-1:0] v_w;
    logic             fill_nxt;
    logic             bevel_nxt;

    assign h_w = {1'b0, pos.hcount};
    assign v_w = {1'b0, pos.vcount};

    assign fill_nxt = platform.enable &&
                      (pos.hcount > platform.x_start) && (pos.hcount < platform.x_end) &&
                      (pos.vcount > platform.y_start) && (pos.vcount < platform.y_end);

    // bevel row k sits k lines above y_start, shifted right by k+1
    always_comb begin
        bevel_nxt = 1'b0;
        for (int k = 0; k < `BEVEL_ROWS; k++) begin
            if ((v_w + SUM_W'(k) == {1'b0, platform.y_start}) &&
                (h_w > {1'b0, platform.x_start} + SUM_W'(k + 1)) &&
                (h_w < {1'b0, platform.x_end} + SUM_W'(k + 1))) begin
                bevel_nxt = platform.enable;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= '0;
        end else begin
            hit.fill  <= fill_nxt;
            hit.bevel <= bevel_nxt;
        end
    end

endmodule

//--- design/pixel_stage.sv
`timescale 1ns/1ps

`include "bg_consts.svh"

module pixel_stage (
    input  logic         clk,
    input  logic         rst,

    vga_bus.sink         in_bus,
    vga_bus.source       stage1_bus,
    output bg_pkg::rgb_t base_rgb,
    output logic         fixed
);

    bg_pkg::rgb_t rgb_nxt;
    logic         fixed_nxt;

    always_comb begin
        fixed_nxt = 1'b1;   // blank and frame edges win over platforms
        if (in_bus.hblnk || in_bus.vblnk) begin
            rgb_nxt = `COL_BLACK;
        end else if (in_bus.vcount == '0) begin
            rgb_nxt = `COL_TOP;
        end else if (in_bus.vcount == bg_pkg::count_t'(`V_PIXELS - 1)) begin
            rgb_nxt = `COL_BOTTOM;
        end else if (in_bus.hcount == '0) begin
            rgb_nxt = `COL_LEFT;
        end else if (in_bus.hcount == bg_pkg::count_t'(`H_PIXELS - 1)) begin
            rgb_nxt = `COL_RIGHT;
        end else begin
            fixed_nxt = 1'b0;
            if (in_bus.vcount == bg_pkg::count_t'(`HORIZON_ROW))
                rgb_nxt = `COL_BLACK;       // horizon line
            else if (in_bus.vcount > bg_pkg::count_t'(`HORIZON_ROW))
                rgb_nxt = `COL_GRASS;
            else
                rgb_nxt = `COL_SKY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_bus.hcount <= '0;
            stage1_bus.vcount <= '0;
            stage1_bus.hsync  <= 1'b0;
            stage1_bus.vsync  <= 1'b0;
            stage1_bus.hblnk  <= 1'b0;
            stage1_bus.vblnk  <= 1'b0;
            base_rgb          <= '0;
            fixed             <= 1'b0;
        end else begin
            stage1_bus.hcount <= in_bus.hcount;
            stage1_bus.vcount <= in_bus.vcount;
            stage1_bus.hsync  <= in_bus.hsync;
            stage1_bus.vsync  <= in_bus.vsync;
            stage1_bus.hblnk  <= in_bus.hblnk;
            stage1_bus.vblnk  <= in_bus.vblnk;
            base_rgb          <= rgb_nxt;
            fixed             <= fixed_nxt;
        end
    end

endmodule

//--- design/color_mux.sv
`timescale 1ns/1ps

`include "bg_consts.svh"

module color_mux (
    input  logic                              clk,
    input  logic                              rst,

    vga_bus.sink                              stage1_bus,
    input  bg_pkg::rgb_t                      base_rgb,
    input  logic                              fixed,
    input  bg_pkg::hit_t [`NUM_PLATFORMS-1:0] hits,

    vga_bus.source                            out_bus,
    output bg_pkg::rgb_t                      rgb
);

    bg_pkg::rgb_t base_q;
    logic         fixed_q;
    logic         any_fill;
    logic         any_bevel;

    // same stage as the registered hits
    always_ff @(posedge clk) begin
        if (rst) begin
            out_bus.hcount <= '0;
            out_bus.vcount <= '0;
            out_bus.hsync  <= 1'b0;
            out_bus.vsync  <= 1'b0;
            out_bus.hblnk  <= 1'b0;
            out_bus.vblnk  <= 1'b0;
            base_q         <= '0;
            fixed_q        <= 1'b0;
        end else begin
            out_bus.hcount <= stage1_bus.hcount;
            out_bus.vcount <= stage1_bus.vcount;
            out_bus.hsync  <= stage1_bus.hsync;
            out_bus.vsync  <= stage1_bus.vsync;
            out_bus.hblnk  <= stage1_bus.hblnk;
            out_bus.vblnk  <= stage1_bus.vblnk;
            base_q         <= base_rgb;
            fixed_q        <= fixed;
        end
    end

    always_comb begin
        any_fill  = 1'b0;
        any_bevel = 1'b0;
        for (int i = 0; i < `NUM_PLATFORMS; i++) begin
            any_fill  = any_fill | hits[i].fill;
            any_bevel = any_bevel | hits[i].bevel;
        end
    end

    // fill beats bevel, both lose to fixed pixels
    assign rgb = fixed_q   ? base_q :
                 any_fill  ? bg_pkg::rgb_t'(`COL_PLATFORM) :
                 any_bevel ? bg_pkg::rgb_t'(`COL_BLACK) :
                             base_q;

endmodule

//--- design/bg_render_top.sv
`timescale 1ns/1ps

`include "bg_consts.svh"

module bg_render_top (
    input  logic                   clk,
    input  logic                   rst,

    input  bg_pkg::count_t         in_hcount,
    input  bg_pkg::count_t         in_vcount,
    input  logic                   in_hsync,
    input  logic                   in_vsync,
    input  logic                   in_hblnk,
    input  logic                   in_vblnk,

    output bg_pkg::count_t         out_hcount,
    output bg_pkg::count_t         out_vcount,
    output logic                   out_hsync,
    output logic                   out_vsync,
    output logic                   out_hblnk,
    output logic                   out_vblnk,
    output bg_pkg::rgb_t           out_rgb,

    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`APB_DATA_W-1:0] pwdata,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    bg_pkg::platform_t [`NUM_PLATFORMS-1:0] platforms;
    bg_pkg::hit_t [`NUM_PLATFORMS-1:0]      hits;
    bg_pkg::rgb_t                           base_rgb;
    logic                                   fixed;

    vga_bus in_bus ();
    vga_bus stage1_bus ();
    vga_bus out_bus ();

    assign in_bus.hcount = in_hcount;
    assign in_bus.vcount = in_vcount;
    assign in_bus.hsync  = in_hsync;
    assign in_bus.vsync  = in_vsync;
    assign in_bus.hblnk  = in_hblnk;
    assign in_bus.vblnk  = in_vblnk;

    assign out_hcount = out_bus.hcount;
    assign out_vcount = out_bus.vcount;
    assign out_hsync  = out_bus.hsync;
    assign out_vsync  = out_bus.vsync;
    assign out_hblnk  = out_bus.hblnk;
    assign out_vblnk  = out_bus.vblnk;

    platform_regs i_platform_regs (
        .clk, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .platforms
    );

    pixel_stage i_pixel_stage (
        .clk, .rst,
        .in_bus     (in_bus),
        .stage1_bus (stage1_bus),
        .base_rgb, .fixed
    );

    for (genvar i = 0; i < `NUM_PLATFORMS; i++) begin : g_platform
        platform_hit i_platform_hit (
            .clk, .rst,
            .pos      (stage1_bus),
            .platform (platforms[i]),
            .hit      (hits[i])
        );
    end

    color_mux i_color_mux (
        .clk, .rst,
        .stage1_bus (stage1_bus),
        .base_rgb, .fixed, .hits,
        .out_bus    (out_bus),
        .rgb        (out_rgb)
    );

endmodule

//--- testbench/tb_bg_tasks.svh
task automatic start_test(string name);
    cur_test    = name;
    test_errors = errors;
endtask

task automatic finish_test();
    if (errors == test_errors) begin
        $display("test %s ok", cur_test);
    end else begin
        tests_failed++;
        $display("test %s failed with %0d errors", cur_test, errors - test_errors);
    end
endtask

task automatic check_rgb(string what, bg_pkg::rgb_t exp, bg_pkg::rgb_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_count(string what, bg_pkg::count_t exp, bg_pkg::count_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("MISMATCH %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
endtask

task automatic check_word(string what, logic [`APB_DATA_W-1:0] exp,
                          logic [`APB_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_flag(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
endtask

task automatic drive_pixel(int h, int v, logic hb, logic vb, logic hs, logic vs);
    in_hcount <= bg_pkg::count_t'(h);
    in_vcount <= bg_pkg::count_t'(v);
    in_hblnk  <= hb;
    in_vblnk  <= vb;
    in_hsync  <= hs;
    in_vsync  <= vs;
endtask

// colour shows two cycles after the pixel is driven
task automatic probe(int h, int v, logic hb, logic vb, bg_pkg::rgb_t exp);
    @(posedge clk);
    drive_pixel(h, v, hb, vb, 1'b0, 1'b0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_rgb($sformatf("pixel (%0d,%0d)", h, v), exp, out_rgb);
endtask

task automatic apb_transfer(logic [`APB_ADDR_W-1:0] addr, logic write,
                            logic [`APB_DATA_W-1:0] wdata,
                            output logic [`APB_DATA_W-1:0] rdata, output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(negedge clk);
    check_flag("pready in setup phase", 1'b0, pready);
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    check_flag("pready in access phase", 1'b1, pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);         // write lands on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic write_reg(int addr, logic [`APB_DATA_W-1:0] data, logic exp_err);
    logic [`APB_DATA_W-1:0] rdata;
    logic                   err;
    apb_transfer(`APB_ADDR_W'(addr), 1'b1, data, rdata, err);
    check_flag($sformatf("pslverr on write to %0d", addr), exp_err, err);
endtask

task automatic read_reg(int addr, logic [`APB_DATA_W-1:0] exp, logic exp_err);
    logic [`APB_DATA_W-1:0] rdata;
    logic                   err;
    apb_transfer(`APB_ADDR_W'(addr), 1'b0, '0, rdata, err);
    check_flag($sformatf("pslverr on read of %0d", addr), exp_err, err);
    if (!exp_err)
        check_word($sformatf("read of %0d", addr), exp, rdata);
endtask

// enable in bit 31, end in 26:16, start in 10:0
function automatic logic [`APB_DATA_W-1:0] span_word(int lo, int hi, logic en);
    return {en, 4'b0, bg_pkg::count_t'(hi), 5'b0, bg_pkg::count_t'(lo)};
endfunction

task automatic set_platform(int i, logic [`APB_DATA_W-1:0] xw, logic [`APB_DATA_W-1:0] yw);
    write_reg(i * `REG_STRIDE + `REG_X_OFFSET, xw, 1'b0);
    write_reg(i * `REG_STRIDE + `REG_Y_OFFSET, yw, 1'b0);
    shadow_x[i] = xw;
    shadow_y[i] = yw;
endtask

// colour rules applied to the shadow registers
function automatic bg_pkg::rgb_t expected_colour(int h, int v, logic blank);
    logic fill;
    logic bevel;
    int   xs, xe, ys, ye;
    fill  = 1'b0;
    bevel = 1'b0;
    if (blank)
        return `COL_BLACK;
    if (v == 0)
        return `COL_TOP;
    if (v == `V_PIXELS - 1)
        return `COL_BOTTOM;
    if (h == 0)
        return `COL_LEFT;
    if (h == `H_PIXELS - 1)
        return `COL_RIGHT;
    for (int i = 0; i < `NUM_PLATFORMS; i++) begin
        xs = int'(shadow_x[i][10:0]);
        xe = int'(shadow_x[i][26:16]);
        ys = int'(shadow_y[i][10:0]);
        ye = int'(shadow_y[i][26:16]);
        if (shadow_x[i][31]) begin
            fill |= h > xs && h < xe && v > ys && v < ye;
            for (int k = 0; k < `BEVEL_ROWS; k++)
                bevel |= v == ys - k && h > xs + 1 + k && h < xe + 1 + k;
        end
    end
    if (fill)
        return `COL_PLATFORM;
    if (bevel || v == `HORIZON_ROW)
        return `COL_BLACK;
    return (v > `HORIZON_ROW) ? `COL_GRASS : `COL_SKY;
endfunction

task automatic reset_values();
    start_test("reset");
    for (int n = 0; n <= 8; n++) begin
        @(posedge clk);
        if (n == 7)
            rst <= 1'b0;    // eight edges with reset high
        @(negedge clk);
        check_rgb("out_rgb", `COL_BLACK, out_rgb);
        check_flag("out timing", 1'b0, |{out_hcount, out_vcount, out_hsync, out_vsync,
                                         out_hblnk, out_vblnk});
        check_flag("pready", 1'b0, pready);
        check_flag("pslverr", 1'b0, pslverr);
    end
    for (int a = 0; a < `NUM_PLATFORMS * `REG_STRIDE; a += 4)
        read_reg(a, '0, 1'b0);
    finish_test();
endtask

task automatic register_access();
    start_test("apb registers");
    for (int i = 0; i < `NUM_PLATFORMS; i++)
        set_platform(i, span_word($urandom_range(2047, 0), $urandom_range(2047, 0), 1'($urandom)),
                     span_word($urandom_range(2047, 0), $urandom_range(2047, 0), 1'b0));
    // writes outside the map change nothing
    write_reg(`NUM_PLATFORMS * `REG_STRIDE, 32'hffff_ffff, 1'b1);
    write_reg(252, 32'hffff_ffff, 1'b1);
    write_reg(2, 32'hffff_ffff, 1'b1);
    read_reg(252, '0, 1'b1);
    for (int i = 0; i < `NUM_PLATFORMS; i++) begin
        read_reg(i * `REG_STRIDE + `REG_X_OFFSET, shadow_x[i], 1'b0);
        read_reg(i * `REG_STRIDE + `REG_Y_OFFSET, shadow_y[i], 1'b0);
    end
    @(negedge clk);
    check_flag("pready when idle", 1'b0, pready);
    finish_test();
endtask

task automatic fixed_colours();
    start_test("fixed colours");
    for (int i = 0; i < `NUM_PLATFORMS; i++)
        set_platform(i, '0, '0);
    probe(500, 300, 1'b1, 1'b0, `COL_BLACK);
    probe(500, 300, 1'b0, 1'b1, `COL_BLACK);
    probe(0, 0, 1'b1, 1'b1, `COL_BLACK);
    probe(500, 0, 1'b0, 1'b0, `COL_TOP);
    probe(0, 0, 1'b0, 1'b0, `COL_TOP);      // corner goes to the top row
    probe(500, 767, 1'b0, 1'b0, `COL_BOTTOM);
    probe(0, 300, 1'b0, 1'b0, `COL_LEFT);
    probe(1023, 300, 1'b0, 1'b0, `COL_RIGHT);
    probe(500, 550, 1'b0, 1'b0, `COL_BLACK);
    probe(500, 551, 1'b0, 1'b0, `COL_GRASS);
    probe(1, 766, 1'b0, 1'b0, `COL_GRASS);
    probe(500, 549, 1'b0, 1'b0, `COL_SKY);
    probe(1, 1, 1'b0, 1'b0, `COL_SKY);
    finish_test();
endtask

task automatic platform_shapes();
    start_test("platforms");
    set_platform(2, span_word(100, 200, 1'b1), span_word(300, 340, 1'b0));
    probe(150, 320, 1'b0, 1'b0, `COL_PLATFORM);
    probe(101, 301, 1'b0, 1'b0, `COL_PLATFORM);
    probe(199, 339, 1'b0, 1'b0, `COL_PLATFORM);
    probe(100, 320, 1'b0, 1'b0, `COL_SKY);
    probe(200, 320, 1'b0, 1'b0, `COL_SKY);
    probe(150, 340, 1'b0, 1'b0, `COL_SKY);
    // bevel rows move right by one per row up
    probe(102, 300, 1'b0, 1'b0, `COL_BLACK);
    probe(101, 300, 1'b0, 1'b0, `COL_SKY);
    probe(200, 300, 1'b0, 1'b0, `COL_BLACK);
    probe(201, 300, 1'b0, 1'b0, `COL_SKY);
    probe(103, 299, 1'b0, 1'b0, `COL_BLACK);
    probe(102, 299, 1'b0, 1'b0, `COL_SKY);
    probe(201, 299, 1'b0, 1'b0, `COL_BLACK);
    probe(202, 299, 1'b0, 1'b0, `COL_SKY);
    probe(104, 298, 1'b0, 1'b0, `COL_BLACK);
    probe(103, 298, 1'b0, 1'b0, `COL_SKY);
    probe(202, 298, 1'b0, 1'b0, `COL_BLACK);
    probe(203, 298, 1'b0, 1'b0, `COL_SKY);
    probe(150, 297, 1'b0, 1'b0, `COL_SKY);
    // spills over the right and bottom edges
    set_platform(3, span_word(900, 1100, 1'b1), span_word(700, 800, 1'b0));
    probe(950, 750, 1'b0, 1'b0, `COL_PLATFORM);
    probe(1023, 750, 1'b0, 1'b0, `COL_RIGHT);
    probe(950, 767, 1'b0, 1'b0, `COL_BOTTOM);
    probe(950, 700, 1'b0, 1'b0, `COL_BLACK);
    set_platform(2, span_word(100, 200, 1'b0), span_word(300, 340, 1'b0));
    probe(150, 320, 1'b0, 1'b0, `COL_SKY);
    probe(150, 300, 1'b0, 1'b0, `COL_SKY);
    set_platform(3, '0, '0);
    finish_test();
endtask

task automatic pixel_stream();
    bg_pkg::rgb_t   exp_rgb [$];
    bg_pkg::count_t exp_hc [$];
    bg_pkg::count_t exp_vc [$];
    logic           exp_hb [$];
    logic           exp_vb [$];
    logic           exp_hs [$];
    logic           exp_vs [$];
    int             h, v, j;
    logic           hb, vb, hs, vs;
    start_test("pixel stream");
    for (int i = 0; i < `NUM_PLATFORMS; i++) begin
        h = $urandom_range(1000, 0);
        v = $urandom_range(740, 0);
        set_platform(i, span_word(h, h + $urandom_range(120, 2), $urandom_range(3, 0) != 0),
                     span_word(v, v + $urandom_range(60, 2), 1'b0));
    end
    for (int n = 0; n < STREAM_LEN + 2; n++) begin
        @(posedge clk);
        if (n < STREAM_LEN) begin
            if ($urandom_range(3, 0) == 0) begin
                h = $urandom_range(`H_PIXELS - 1, 0);
                v = $urandom_range(`V_PIXELS - 1, 0);
            end else begin
                // near a platform so the strict bounds get exercised
                j = $urandom_range(`NUM_PLATFORMS - 1, 0);
                h = int'(shadow_x[j][10:0]) - 4 + int'($urandom_range(130, 0));
                v = int'(shadow_y[j][10:0]) - 4 + int'($urandom_range(70, 0));
            end
            h  = (h < 0) ? 0 : (h >= `H_PIXELS) ? `H_PIXELS - 1 : h;
            v  = (v < 0) ? 0 : (v >= `V_PIXELS) ? `V_PIXELS - 1 : v;
            hb = ($urandom_range(15, 0) == 0);
            vb = ($urandom_range(15, 0) == 0);
            hs = 1'($urandom);
            vs = 1'($urandom);
            drive_pixel(h, v, hb, vb, hs, vs);
            exp_rgb.push_back(expected_colour(h, v, hb || vb));
            exp_hc.push_back(bg_pkg::count_t'(h));
            exp_vc.push_back(bg_pkg::count_t'(v));
            exp_hb.push_back(hb);
            exp_vb.push_back(vb);
            exp_hs.push_back(hs);
            exp_vs.push_back(vs);
        end
        @(negedge clk);
        if (n >= 2) begin
            check_rgb($sformatf("pixel %0d", n - 2), exp_rgb.pop_front(), out_rgb);
            check_count("out_hcount", exp_hc.pop_front(), out_hcount);
            check_count("out_vcount", exp_vc.pop_front(), out_vcount);
            check_flag("out_hblnk", exp_hb.pop_front(), out_hblnk);
            check_flag("out_vblnk", exp_vb.pop_front(), out_vblnk);
            check_flag("out_hsync", exp_hs.pop_front(), out_hsync);
            check_flag("out_vsync", exp_vs.pop_front(), out_vsync);
        end
    end
    finish_test();
endtask

//--- testbench/tb_bg_render.sv
`timescale 1ns/1ps

`include "bg_consts.svh"

module tb_bg_render;

    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 400;   // pixel stream is the longest
    localparam int MARGIN      = 100;
    localparam int STREAM_LEN  = 300;

    logic                   clk;
    logic                   rst;
    bg_pkg::count_t         in_hcount, in_vcount;
    logic                   in_hsync, in_vsync, in_hblnk, in_vblnk;
    bg_pkg::count_t         out_hcount, out_vcount;
    logic                   out_hsync, out_vsync, out_hblnk, out_vblnk;
    bg_pkg::rgb_t           out_rgb;
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel, penable, pwrite;
    logic [`APB_DATA_W-1:0] pwdata, prdata;
    logic                   pready, pslverr;

    // what the platform registers should hold
    logic [`APB_DATA_W-1:0] shadow_x [`NUM_PLATFORMS] = '{default: '0};
    logic [`APB_DATA_W-1:0] shadow_y [`NUM_PLATFORMS] = '{default: '0};

    string cur_test     = "startup";
    int    checks       = 0;
    int    errors       = 0;
    int    test_errors  = 0;
    int    tests_failed = 0;

    bg_render_top i_bg_render_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES + MARGIN) @(posedge clk);
        $display("ERROR: watchdog expired during test %s, the run made no progress", cur_test);
        $display("RESULT: FAIL");
        $finish;
    end

    `include "tb_bg_tasks.svh"

    initial begin
        void'($urandom(32'h146a));
        rst       <= 1'b1;
        in_hcount <= '0;
        in_vcount <= '0;
        in_hsync  <= 1'b0;
        in_vsync  <= 1'b0;
        in_hblnk  <= 1'b0;
        in_vblnk  <= 1'b0;
        paddr     <= '0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        pwdata    <= '0;

        reset_values();
        register_access();
        fixed_colours();
        platform_shapes();
        pixel_stream();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- compile.f
+incdir+common
+incdir+testbench
common/bg_pkg.sv
common/vga_bus.sv
platforms/platform_regs.sv
platforms/platform_hit.sv
design/pixel_stage.sv
design/color_mux.sv
design/bg_render_top.sv
testbench/tb_bg_render.sv

//--- Makefile
# verilator build and run of the colour stage testbench

sim:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module tb_bg_render -o tb_bg_render
	./obj_dir/tb_bg_render | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
